// ==== adc_monitor.f ====
verilog/adc_pkg.sv
verilog/uart_pkg.sv
verilog/uart_byte_if.sv
verilog/spi_adc_capture.sv
verilog/peak_cache.sv
verilog/uart_transceiver.sv
verilog/command_controller.sv
verilog/adc_monitor.sv
testbench/tb_adc_monitor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_adc_monitor
FILELIST  ?= adc_monitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/adc_monitor_stimulus.txt ====
# name ch0 ch1 ch2 ch3 frames cmd count reply0 reply1
# values and bytes in hex; count 0 sends no command, unused reply bytes are 00
reset_read_1 000 000 000 000 0 31 2 41 00
reset_read_4 000 000 000 000 0 34 2 44 00
ch2_rise 000 000 100 000 2 00 0 00 00
ch2_top 000 000 3A7 000 2 00 0 00 00
ch2_fall 000 000 0C0 000 3 33 2 43 E9
ch2_clear 000 000 050 000 2 33 2 43 30
ch2_again 000 000 050 000 1 33 2 43 14
chan_load 2C8 155 050 3FF 2 00 0 00 00
chan_read_1 012 008 050 010 1 31 2 41 B2
chan_read_2 012 008 050 010 1 32 2 42 55
chan_read_4 012 008 050 010 1 34 2 44 FF
unknown_0 012 008 050 2A0 1 30 1 3F 00
unknown_5 012 008 050 2A0 1 35 1 3F 00
unknown_x 012 008 050 2A0 1 78 1 3F 00
kept_4 012 008 050 001 1 34 2 44 A8
kept_1 012 008 050 001 1 31 2 41 04
kept_3 012 008 050 001 1 33 2 43 14

// ==== testbench/tb_adc_monitor.sv ====
// Stimulus file is opened relative to the project root; test names must stay under 16 characters
`timescale 1ns/1ps
`default_nettype none

module tb_adc_monitor;

    localparam int spi_half_period = 2;
    localparam int clks_per_bit    = 8;
    localparam int frame_clks      = 2 * spi_half_period * 18;
    localparam int line_uart_clks  = 3 * 10 * clks_per_bit * 4;
    localparam int max_lines       = 32;
    localparam logic [7:0] ascii_one      = 8'h31;
    localparam logic [7:0] ascii_a        = 8'h41;
    localparam logic [7:0] ascii_question = 8'h3F;

    logic       clk = 1'b0;
    logic       reset_b = 1'b0;
    logic       uart_rx = 1'b1;
    logic [3:0] adc_miso;
    logic       adc_sclk;
    logic       adc_cs_n;
    logic       uart_tx;

    // ADC model state
    logic [9:0]  adc_value [4] = '{default: '0};
    logic [15:0] adc_frame [4] = '{default: '0};
    logic        prev_sclk = 1'b0;

    // Stimulus table
    logic [8*16-1:0] test_names [max_lines];
    logic [9:0]      line_values [max_lines][4];
    int              line_frames [max_lines];
    logic [7:0]      line_cmd [max_lines];
    int              line_count [max_lines];
    logic [7:0]      line_reply [max_lines][2];
    int              num_lines = 0;

    logic [9:0] exp_peak [4] = '{default: '0};
    logic [7:0] rx_bytes [2];
    logic [7:0] cmd_byte;
    int         reply_len;
    string      cur_test;
    int         error_count = 0;
    int         failed_tests = 0;
    int         cycle_count = 0;
    int         cycle_limit = 1000;

    adc_monitor #(
        .SPI_HALF_PERIOD(spi_half_period),
        .CLKS_PER_BIT(clks_per_bit)
    ) i_adc_monitor (
        .clk, .reset_b, .adc_miso, .adc_sclk, .adc_cs_n, .uart_rx, .uart_tx
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run passed its limit of %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // Four ADCs, frame is 4 zeros, 10 data bits MSB first, 2 zeros
    assign adc_miso = {adc_frame[3][15], adc_frame[2][15], adc_frame[1][15], adc_frame[0][15]};

    always @(negedge clk) begin
        for (int ch = 0; ch < 4; ch++) begin
            if (adc_cs_n) begin
                adc_frame[ch] <= {4'b0000, adc_value[ch], 2'b00};
            end else if (prev_sclk && !adc_sclk) begin
                adc_frame[ch] <= {adc_frame[ch][14:0], 1'b0};
            end
        end
        prev_sclk <= adc_sclk;
    end

    task automatic compare(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input int errors_before);
        if (error_count == errors_before) begin
            $display("Test %s passed", cur_test);
        end else begin
            $display("Test %s failed", cur_test);
            failed_tests++;
        end
    endtask

    task automatic load_stimulus();
        int              fd;
        int              code;
        int              c;
        int              frames;
        int              count;
        logic [8*16-1:0] token;
        logic [9:0]      v [4];
        logic [7:0]      cmd;
        logic [7:0]      r0;
        logic [7:0]      r1;
        fd = $fopen("testbench/adc_monitor_stimulus.txt", "r");
        if (fd == 0) begin
            $display("The stimulus file testbench/adc_monitor_stimulus.txt could not be opened");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", token) == 1) begin
            if (token[8*16-1:8] == '0 && token[7:0] == 8'h23) begin
                // Comment line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%h %h %h %h %d %h %d %h %h",
                               v[0], v[1], v[2], v[3], frames, cmd, count, r0, r1);
                if (code != 9 || num_lines == max_lines) begin
                    $display("Stimulus line %0d is malformed or beyond the table", num_lines + 1);
                    error_count++;
                    break;
                end
                test_names[num_lines] = token;
                for (int ch = 0; ch < 4; ch++) begin
                    line_values[num_lines][ch] = v[ch];
                end
                line_frames[num_lines]   = frames;
                line_cmd[num_lines]      = cmd;
                line_count[num_lines]    = count;
                line_reply[num_lines][0] = r0;
                line_reply[num_lines][1] = r1;
                num_lines++;
            end
        end
        $fclose(fd);
        if (num_lines == 0) begin
            $display("The stimulus file holds no tests");
            error_count++;
        end
    endtask

    // New values go in during the gap, so the next frame carries them
    task automatic apply_values(input int idx);
        @(posedge adc_cs_n);
        @(negedge clk);
        for (int ch = 0; ch < 4; ch++) begin
            adc_value[ch] = line_values[idx][ch];
            if (line_values[idx][ch] > exp_peak[ch]) begin
                exp_peak[ch] = line_values[idx][ch];
            end
        end
        repeat (line_frames[idx]) @(posedge adc_cs_n);
    endtask

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            uart_rx = bits[i];
            repeat (clks_per_bit - 1) @(negedge clk);
        end
    endtask

    // Samples near the middle of each bit, LSB first
    task automatic receive_byte(output logic [7:0] data);
        data = '0;
        @(negedge clk);
        while (uart_tx) begin
            @(negedge clk);
        end
        repeat (clks_per_bit / 2) @(negedge clk);
        compare("start bit", 0, int'(uart_tx));
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        compare("stop bit", 1, int'(uart_tx));
    endtask

    // No further start bit may follow the reply
    task automatic check_line_idle();
        logic stayed_high;
        stayed_high = 1'b1;
        repeat (2 * clks_per_bit) begin
            @(negedge clk);
            if (!uart_tx) begin
                stayed_high = 1'b0;
            end
        end
        compare("line idle after reply", 1, int'(stayed_high));
    endtask

    task automatic run_line(input int idx);
        int         errors_before;
        int         ch;
        logic       valid;
        logic [7:0] want [2];
        errors_before = error_count;
        cur_test = $sformatf("%0s", test_names[idx]);
        apply_values(idx);
        if (line_count[idx] > 0) begin
            ch    = int'(line_cmd[idx]) - int'(ascii_one);
            valid = (ch >= 0) && (ch < 4);
            if (valid) begin
                want[0] = 8'(int'(ascii_a) + ch);
                want[1] = exp_peak[ch][9:2];
            end else begin
                want[0] = ascii_question;
                want[1] = 8'h00;
            end
            reply_len = valid ? 2 : 1;
            compare("reply count in file", reply_len, line_count[idx]);
            for (int i = 0; i < reply_len; i++) begin
                compare($sformatf("file byte %0d", i), int'(want[i]), int'(line_reply[idx][i]));
            end
            cmd_byte = line_cmd[idx];
            fork
                send_byte(cmd_byte);
                begin
                    for (int i = 0; i < reply_len; i++) begin
                        receive_byte(rx_bytes[i]);
                    end
                end
            join
            check_line_idle();
            for (int i = 0; i < reply_len; i++) begin
                compare($sformatf("reply byte %0d", i), int'(want[i]), int'(rx_bytes[i]));
            end
            // Frames during the reply all carry the held value
            if (valid) begin
                exp_peak[ch] = adc_value[ch];
            end
        end
        report_test(errors_before);
    endtask

    initial begin
        int reset_errors;
        load_stimulus();
        for (int i = 0; i < num_lines; i++) begin
            cycle_limit += line_frames[i] * frame_clks + line_uart_clks;
        end
        repeat (4) @(negedge clk);
        reset_b = 1'b1;

        reset_errors = error_count;
        cur_test = "reset_idle";
        compare("uart_tx", 1, int'(uart_tx));
        compare("adc_cs_n", 1, int'(adc_cs_n));
        compare("adc_sclk", 0, int'(adc_sclk));
        report_test(reset_errors);

        for (int i = 0; i < num_lines; i++) begin
            run_line(i);
        end

        $display("%0d tests run, %0d failed, %0d errors", num_lines + 1, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/adc_monitor.sv ====
// Single clock domain; serial clock and UART bit rate both come from clk by division
`timescale 1ns/1ps
`default_nettype none

module adc_monitor #(
    parameter int SPI_HALF_PERIOD = 2,
    parameter int CLKS_PER_BIT    = 8
) (
    input  logic       clk,
    input  logic       reset_b,
    input  logic [3:0] adc_miso,
    output logic       adc_sclk,
    output logic       adc_cs_n,
    input  logic       uart_rx,
    output logic       uart_tx
);
    import adc_pkg::*;

    adc_sample_t samples [num_channels];
    adc_sample_t peak;
    channel_t    read_channel;
    logic        sample_valid;
    logic        read_en;

    uart_byte_if byte_if ();

    spi_adc_capture #(.SPI_HALF_PERIOD(SPI_HALF_PERIOD)) i_spi_adc_capture (
        .clk, .reset_b, .adc_miso, .adc_sclk, .adc_cs_n, .samples, .sample_valid
    );

    peak_cache i_peak_cache (
        .clk, .reset_b, .samples, .sample_valid, .read_en, .read_channel, .peak
    );

    command_controller i_command_controller (
        .clk, .reset_b, .peak, .read_en, .read_channel, .byte_if(byte_if.ctrl)
    );

    uart_transceiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_transceiver (
        .clk, .reset_b, .uart_rx, .uart_tx, .byte_if(byte_if.uart)
    );

endmodule

`default_nettype wire

// ==== verilog/command_controller.sv ====
// One command at a time; bytes arriving while a reply is pending are dropped
`timescale 1ns/1ps
`default_nettype none

module command_controller (
    input  logic                 clk,
    input  logic                 reset_b,
    input  adc_pkg::adc_sample_t peak,
    output logic                 read_en,
    output adc_pkg::channel_t    read_channel,
    uart_byte_if.ctrl            byte_if
);
    import adc_pkg::*;
    import uart_pkg::*;

    typedef enum logic [1:0] {idle, send_first, send_second} state_t;

    state_t     state;
    logic       two_bytes;
    logic       cmd_is_channel;
    logic       accept;
    uart_byte_t cmd_offset;
    uart_byte_t first_byte;
    uart_byte_t second_byte;

    // Wraps below '1', so only '1' to '4' land in range
    assign cmd_offset     = byte_if.rx_data - cmd_channel_base;
    assign cmd_is_channel = (cmd_offset < uart_byte_t'(num_channels));
    assign accept         = (state == idle) && byte_if.rx_valid;
    assign read_channel   = cmd_offset[$bits(channel_t)-1:0];
    assign read_en        = accept && cmd_is_channel;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state     <= idle;
            two_bytes <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state     <= send_first;
                        two_bytes <= cmd_is_channel;
                    end
                end
                send_first: begin
                    if (byte_if.tx_ready) state <= two_bytes ? send_second : idle;
                end
                default: begin
                    if (byte_if.tx_ready) state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            first_byte  <= cmd_is_channel ?
                           reply_channel_base + uart_byte_t'(read_channel) : reply_unknown;
            second_byte <= peak[$bits(adc_sample_t)-1 -: $bits(uart_byte_t)];
        end
    end

    assign byte_if.tx_valid = (state != idle);
    assign byte_if.tx_data  = (state == send_second) ? second_byte : first_byte;

    a_tx_hold: assert property (@(posedge clk) disable iff (!reset_b)
        byte_if.tx_valid && !byte_if.tx_ready |=> byte_if.tx_valid && $stable(byte_if.tx_data))
        else $error("tx byte changed before the UART took it");

endmodule

`default_nettype wire

// ==== verilog/uart_transceiver.sv ====
// 8N1 only, no parity or break detection; CLKS_PER_BIT must be at least 2
`timescale 1ns/1ps
`default_nettype none

module uart_transceiver #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       uart_rx,
    output logic       uart_tx,
    uart_byte_if.uart  byte_if
);
    import uart_pkg::*;

    localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(CLKS_PER_BIT - 1);
    localparam logic [cnt_w-1:0] bit_mid = cnt_w'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    rx_state_t        rx_state;
    logic [1:0]       rx_sync;
    logic             rx_line;
    logic [cnt_w-1:0] rx_cnt;
    logic [2:0]       rx_idx;
    logic             rx_bit_tick;
    logic             rx_valid_q;
    uart_byte_t       rx_shift;

    logic             tx_busy;
    logic [cnt_w-1:0] tx_cnt;
    logic [3:0]       tx_idx;
    logic             tx_start;
    logic             tx_tick;
    logic [8:0]       tx_shift;

    // Receiver
    assign rx_line     = rx_sync[1];
    assign rx_bit_tick = (rx_state == rx_data) && (rx_cnt == bit_last);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_sync    <= 2'b11;
            rx_state   <= rx_idle;
            rx_cnt     <= '0;
            rx_idx     <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], uart_rx};
            rx_valid_q <= 1'b0;
            rx_cnt     <= rx_cnt + 1'b1;
            case (rx_state)
                rx_idle: begin
                    rx_cnt <= '0;
                    rx_idx <= '0;
                    if (!rx_line) rx_state <= rx_start;
                end
                rx_start: begin
                    // Recheck the line halfway through the start bit
                    if (rx_cnt == bit_mid) begin
                        rx_cnt   <= '0;
                        rx_state <= rx_line ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (rx_bit_tick) begin
                        rx_cnt <= '0;
                        rx_idx <= rx_idx + 1'b1;
                        if (rx_idx == 3'd7) rx_state <= rx_stop;
                    end
                end
                default: begin
                    if (rx_cnt == bit_last) begin
                        rx_valid_q <= rx_line;
                        rx_state   <= rx_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_bit_tick) rx_shift <= {rx_line, rx_shift[7:1]};
    end

    assign byte_if.rx_data  = rx_shift;
    assign byte_if.rx_valid = rx_valid_q;

    // Transmitter
    assign tx_start         = !tx_busy && byte_if.tx_valid;
    assign tx_tick          = tx_busy && (tx_cnt == bit_last);
    assign byte_if.tx_ready = !tx_busy;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            tx_busy <= 1'b0;
            tx_cnt  <= '0;
            tx_idx  <= '0;
            uart_tx <= 1'b1;
        end else if (tx_start) begin
            tx_busy <= 1'b1;
            tx_cnt  <= '0;
            tx_idx  <= '0;
            uart_tx <= 1'b0;
        end else if (tx_tick) begin
            tx_cnt <= '0;
            if (tx_idx == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                uart_tx <= tx_shift[0];
                tx_idx  <= tx_idx + 1'b1;
            end
        end else if (tx_busy) begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    // Data LSB first, stop bit sits above it
    always_ff @(posedge clk) begin
        if (tx_start) begin
            tx_shift <= {1'b1, byte_if.tx_data};
        end else if (tx_tick) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

    a_rx_pulse: assert property (@(posedge clk) disable iff (!reset_b)
        byte_if.rx_valid |=> !byte_if.rx_valid)
        else $error("rx_valid held for two cycles");

endmodule

`default_nettype wire

// ==== verilog/peak_cache.sv ====
// A read clears the channel; a sample on the same edge becomes the new peak
`timescale 1ns/1ps
`default_nettype none

module peak_cache (
    input  logic                 clk,
    input  logic                 reset_b,
    input  adc_pkg::adc_sample_t samples [adc_pkg::num_channels],
    input  logic                 sample_valid,
    input  logic                 read_en,
    input  adc_pkg::channel_t    read_channel,
    output adc_pkg::adc_sample_t peak
);
    import adc_pkg::*;

    adc_sample_t peaks [num_channels];

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int ch = 0; ch < num_channels; ch++) begin
                peaks[ch] <= '0;
            end
        end else begin
            for (int ch = 0; ch < num_channels; ch++) begin
                if (read_en && (read_channel == channel_t'(ch))) begin
                    // Restart the running maximum from this frame, if any
                    peaks[ch] <= sample_valid ? samples[ch] : '0;
                end else if (sample_valid && (samples[ch] > peaks[ch])) begin
                    peaks[ch] <= samples[ch];
                end
            end
        end
    end

    // Read port, no latency
    assign peak = peaks[read_channel];

endmodule

`default_nettype wire

// ==== verilog/spi_adc_capture.sv ====
// Free-running capture; ADCs must change data on falling sclk, one frame every 36*SPI_HALF_PERIOD clk
`timescale 1ns/1ps
`default_nettype none

module spi_adc_capture #(
    parameter int SPI_HALF_PERIOD = 2
) (
    input  logic                 clk,
    input  logic                 reset_b,
    input  logic [adc_pkg::num_channels-1:0] adc_miso,
    output logic                 adc_sclk,
    output logic                 adc_cs_n,
    output adc_pkg::adc_sample_t samples [adc_pkg::num_channels],
    output logic                 sample_valid
);
    import adc_pkg::*;

    localparam int total_bits = adc_frame_bits + adc_gap_bits;
    localparam int half_w = $clog2(SPI_HALF_PERIOD + 1);
    localparam int bit_w = $clog2(total_bits + 1);
    localparam logic [half_w-1:0] half_last = half_w'(SPI_HALF_PERIOD - 1);
    localparam logic [bit_w-1:0] bit_last = bit_w'(total_bits - 1);
    localparam logic [bit_w-1:0] frame_end = bit_w'(adc_frame_bits);
    localparam logic [bit_w-1:0] cap_first = bit_w'(adc_lead_bits);
    localparam logic [bit_w-1:0] cap_last = bit_w'(adc_lead_bits + $bits(adc_sample_t) - 1);

    logic [half_w-1:0] half_cnt;
    logic [bit_w-1:0]  bit_cnt;
    logic [bit_w-1:0]  next_bit;
    logic              phase;
    logic              half_done;
    logic              rise_tick;
    logic              fall_tick;
    logic              capture_en;

    assign half_done  = (half_cnt == half_last);
    assign rise_tick  = half_done && !phase;
    assign fall_tick  = half_done && phase;
    assign next_bit   = (bit_cnt == bit_last) ? '0 : bit_cnt + 1'b1;
    // Data bits 5 to 14 of the frame, counted from 1
    assign capture_en = rise_tick && (bit_cnt >= cap_first) && (bit_cnt <= cap_last);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            half_cnt     <= '0;
            phase        <= 1'b0;
            bit_cnt      <= frame_end;
            adc_sclk     <= 1'b0;
            adc_cs_n     <= 1'b1;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            half_cnt     <= half_done ? '0 : half_cnt + 1'b1;
            if (rise_tick) begin
                phase    <= 1'b1;
                adc_sclk <= (bit_cnt < frame_end);
            end else if (fall_tick) begin
                phase        <= 1'b0;
                adc_sclk     <= 1'b0;
                bit_cnt      <= next_bit;
                adc_cs_n     <= (next_bit >= frame_end);
                sample_valid <= (next_bit == frame_end);
            end
        end
    end

    // All channels shift together, MSB first
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < num_channels; ch++) begin
            if (capture_en) begin
                samples[ch] <= {samples[ch][$bits(adc_sample_t)-2:0], adc_miso[ch]};
            end
        end
    end

    a_sclk_idle: assert property (@(posedge clk) disable iff (!reset_b)
        adc_cs_n |-> !adc_sclk)
        else $error("sclk toggled with chip select high");

endmodule

`default_nettype wire

// ==== verilog/uart_byte_if.sv ====
// Byte stream between UART and controller; rx has no back-pressure, tx uses valid/ready
`timescale 1ns/1ps
`default_nettype none

interface uart_byte_if;
    import uart_pkg::*;

    uart_byte_t rx_data;
    logic       rx_valid;
    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;

    modport uart (output rx_data, rx_valid, tx_ready, input tx_data, tx_valid);
    modport ctrl (input rx_data, rx_valid, tx_ready, output tx_data, tx_valid);

endinterface

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
// Command and reply codes are plain ASCII; only '1' to '4' are valid commands
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // ASCII '1', selects channel 0
    localparam uart_byte_t cmd_channel_base = 8'h31;

    // ASCII 'A', letter of channel 0 in a reply
    localparam uart_byte_t reply_channel_base = 8'h41;

    // ASCII '?', answer to any other byte
    localparam uart_byte_t reply_unknown = 8'h3F;

endpackage

`default_nettype wire

// ==== verilog/adc_pkg.sv ====
// ADC frame layout assumes 10-bit converters with 4 leading zeros and 2 trailing zeros per frame
`default_nettype none

package adc_pkg;

    // Number of ADCs read in parallel
    localparam int num_channels = 4;

    typedef logic [9:0] adc_sample_t;
    typedef logic [1:0] channel_t;

    // Frame layout in serial clock periods
    localparam int adc_lead_bits  = 4;
    localparam int adc_frame_bits = 16;
    localparam int adc_gap_bits   = 2;

endpackage

`default_nettype wire
